// ==== design/nnLayer_cfg.svh ====
`ifndef NN_LAYER_CFG_SVH
`define NN_LAYER_CFG_SVH

// frame and layer geometry
`define NN_FEATURES 15
`define NN_NEURONS 4

// the score is the accumulator shifted right by this many bits
`define NN_FRAC_SHIFT 6
`define NN_SAT_MAX 127

// weight vectors are packed with feature 14 in the top byte and feature 0 in the bottom byte
`define NN_W0 {8'sd8, 8'sd40, -8'sd24, -8'sd26, 8'sd42, -8'sd10, 8'sd28, 8'sd22, \
	8'sd4, -8'sd28, 8'sd62, -8'sd18, 8'sd46, -8'sd22, 8'sd8}
`define NN_W1 {-8'sd12, 8'sd30, 8'sd6, -8'sd20, 8'sd14, 8'sd36, -8'sd8, 8'sd10, \
	-8'sd32, 8'sd18, 8'sd2, 8'sd24, -8'sd16, 8'sd12, 8'sd20}
`define NN_W2 {8'sd20, -8'sd6, 8'sd16, 8'sd34, -8'sd14, 8'sd8, 8'sd26, -8'sd30, \
	8'sd12, 8'sd4, -8'sd18, 8'sd22, 8'sd38, -8'sd10, -8'sd4}
`define NN_W3 {-8'sd2, 8'sd14, -8'sd36, 8'sd10, 8'sd24, -8'sd20, 8'sd18, 8'sd6, \
	-8'sd12, 8'sd30, 8'sd16, -8'sd8, 8'sd4, 8'sd26, -8'sd22}

// biases sit at product scale, so 64 is one score step
`define NN_B0 -16'sd1536
`define NN_B1 16'sd640
`define NN_B2 16'sd0
`define NN_B3 16'sd320

`endif

// ==== design/nnPkg.sv ====
package nnPkg;

	// input feature or neuron score
	typedef logic signed [7:0] feature_t;

	typedef logic signed [7:0] weight_t;

	// one feature times one weight
	typedef logic signed [15:0] product_t;

	// fifteen products plus the bias fit without overflow
	typedef logic signed [22:0] accum_t;

	typedef logic signed [15:0] bias_t;

	// index of the winning neuron
	typedef logic [1:0] classId_t;

	typedef enum logic [1:0]
	{
		LD_IDLE,
		LD_CAPTURE,
		LD_WAITDROP,
		LD_BUSY
	} loaderState_t;

	typedef enum logic [1:0]
	{
		RS_IDLE,
		RS_OFFER,
		RS_WAITDROP
	} resultState_t;

endpackage

// ==== design/featureLoader.sv ====
`timescale 1ns/10ps
`include "nnLayer_cfg.svh"

module featureLoader
(
	input logic clk,
	input logic reset,
	input logic featureReq,
	input nnPkg::feature_t featureData,
	output logic featureAck,
	input logic frameDone,
	output nnPkg::feature_t [`NN_FEATURES-1:0] featureBank,
	output logic frameValid
);

	localparam int countWidth = $clog2(`NN_FEATURES);
	localparam logic [countWidth-1:0] lastSlot = countWidth'(`NN_FEATURES - 1);

	nnPkg::loaderState_t state;
	logic [countWidth-1:0] featureCount;
	logic launch; // frame is complete, frameValid goes out next cycle

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnPkg::LD_IDLE;
			featureCount <= '0;
			featureAck <= 1'b0;
			featureBank <= '0;
			launch <= 1'b0;
			frameValid <= 1'b0;
		end
		else
		begin
			frameValid <= launch;
			launch <= 1'b0;
			case (state)
				nnPkg::LD_IDLE:
				begin
					if (featureReq)
						state <= nnPkg::LD_CAPTURE;
				end
				nnPkg::LD_CAPTURE:
				begin
					featureBank[featureCount] <= featureData; // host holds data while req is high
					featureAck <= 1'b1;
					state <= nnPkg::LD_WAITDROP;
				end
				nnPkg::LD_WAITDROP:
				begin
					if (!featureReq)
					begin
						featureAck <= 1'b0;
						if (featureCount == lastSlot)
						begin
							featureCount <= '0;
							launch <= 1'b1;
							state <= nnPkg::LD_BUSY;
						end
						else
						begin
							featureCount <= featureCount + 1'b1;
							state <= nnPkg::LD_IDLE;
						end
					end
				end
				nnPkg::LD_BUSY:
				begin
					// the bank feeds the neurons until the result handshake is over
					if (frameDone)
						state <= nnPkg::LD_IDLE;
				end
				default:
					state <= nnPkg::LD_IDLE;
			endcase
		end
	end

endmodule

// ==== design/neuron.sv ====
`timescale 1ns/10ps
`include "nnLayer_cfg.svh"

module neuron
#(
	parameter nnPkg::weight_t [`NN_FEATURES-1:0] weights = '0,
	parameter nnPkg::bias_t bias = '0
)
(
	input logic clk,
	input logic reset,
	input nnPkg::feature_t [`NN_FEATURES-1:0] featureBank,
	input logic frameValid,
	output nnPkg::feature_t score,
	output logic scoreValid
);

	localparam int fracShift = `NN_FRAC_SHIFT;
	localparam int scoreWidth = $bits(nnPkg::feature_t);
	localparam int signBit = $bits(nnPkg::accum_t) - 1;
	localparam int highLow = fracShift + scoreWidth - 1; // lowest bit of the overflow field
	localparam logic [scoreWidth-1:0] satMax = scoreWidth'(`NN_SAT_MAX);

	nnPkg::feature_t [`NN_FEATURES-1:0] featureReg;
	nnPkg::product_t products [`NN_FEATURES];
	nnPkg::accum_t sumNext;
	nnPkg::accum_t accum;
	logic roundUp;
	logic [scoreWidth:0] rounded;
	nnPkg::feature_t scoreNext;
	logic [2:0] validPipe;

	// stage 1 products come straight off the registered features
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < `NN_FEATURES; i++)
		begin
			products[i] = featureReg[i] * weights[i];
			sumNext = sumNext + products[i];
		end
	end

	// ReLU, then round half down and saturate
	always_comb
	begin
		roundUp = accum[fracShift-1] && (accum[fracShift-2:0] != '0);
		rounded = {1'b0, accum[fracShift +: scoreWidth]} + (scoreWidth+1)'(roundUp);
		if (accum[signBit])
			scoreNext = '0;
		else if (accum[signBit-1:highLow] != '0)
			scoreNext = satMax;
		else if (rounded > {1'b0, satMax})
			scoreNext = satMax; // rounding carried past the limit
		else
			scoreNext = rounded[scoreWidth-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featureReg <= '0;
			accum <= '0;
			score <= '0;
			validPipe <= '0;
		end
		else
		begin
			featureReg <= featureBank;
			accum <= sumNext;
			score <= scoreNext;
			validPipe <= {validPipe[1:0], frameValid};
		end
	end

	assign scoreValid = validPipe[2];

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/10ps
`include "nnLayer_cfg.svh"

module resultStage
(
	input logic clk,
	input logic reset,
	input nnPkg::feature_t score0,
	input nnPkg::feature_t score1,
	input nnPkg::feature_t score2,
	input nnPkg::feature_t score3,
	input logic scoreValid,
	output logic resultReq,
	input logic resultAck,
	output nnPkg::classId_t classId,
	output nnPkg::feature_t scoreOut0,
	output nnPkg::feature_t scoreOut1,
	output nnPkg::feature_t scoreOut2,
	output nnPkg::feature_t scoreOut3,
	output logic frameDone
);

	nnPkg::resultState_t state;
	nnPkg::feature_t scoresIn [`NN_NEURONS];
	nnPkg::feature_t bestScore;
	nnPkg::classId_t bestId;

	assign scoresIn[0] = score0;
	assign scoresIn[1] = score1;
	assign scoresIn[2] = score2;
	assign scoresIn[3] = score3;

	always_comb
	begin
		bestId = '0;
		bestScore = scoresIn[0];
		for (int i = 1; i < `NN_NEURONS; i++)
		begin
			if (scoresIn[i] > bestScore) // strict compare keeps the lower index on a tie
			begin
				bestId = nnPkg::classId_t'(i);
				bestScore = scoresIn[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnPkg::RS_IDLE;
			resultReq <= 1'b0;
			frameDone <= 1'b0;
			classId <= '0;
			scoreOut0 <= '0;
			scoreOut1 <= '0;
			scoreOut2 <= '0;
			scoreOut3 <= '0;
		end
		else
		begin
			frameDone <= 1'b0;
			case (state)
				nnPkg::RS_IDLE:
				begin
					if (scoreValid)
					begin
						classId <= bestId;
						scoreOut0 <= score0;
						scoreOut1 <= score1;
						scoreOut2 <= score2;
						scoreOut3 <= score3;
						resultReq <= 1'b1;
						state <= nnPkg::RS_OFFER;
					end
				end
				nnPkg::RS_OFFER:
				begin
					if (resultAck)
					begin
						resultReq <= 1'b0;
						state <= nnPkg::RS_WAITDROP;
					end
				end
				nnPkg::RS_WAITDROP:
				begin
					if (!resultAck)
					begin
						frameDone <= 1'b1; // releases the loader for the next frame
						state <= nnPkg::RS_IDLE;
					end
				end
				default:
					state <= nnPkg::RS_IDLE;
			endcase
		end
	end

endmodule

// ==== design/nnLayer.sv ====
`timescale 1ns/10ps
`include "nnLayer_cfg.svh"

module nnLayer
(
	input logic clk,
	input logic reset,
	input logic featureReq,
	input nnPkg::feature_t featureData,
	output logic featureAck,
	output logic resultReq,
	input logic resultAck,
	output nnPkg::classId_t classId,
	output nnPkg::feature_t score0,
	output nnPkg::feature_t score1,
	output nnPkg::feature_t score2,
	output nnPkg::feature_t score3
);

	nnPkg::feature_t [`NN_FEATURES-1:0] featureBank;
	logic frameValid;
	logic frameDone;
	logic scoreValid;
	nnPkg::feature_t neuronScore0;
	nnPkg::feature_t neuronScore1;
	nnPkg::feature_t neuronScore2;
	nnPkg::feature_t neuronScore3;

	featureLoader i_featureLoader
	(
		.clk(clk),
		.reset(reset),
		.featureReq(featureReq),
		.featureData(featureData),
		.featureAck(featureAck),
		.frameDone(frameDone),
		.featureBank(featureBank),
		.frameValid(frameValid)
	);

	// all four neurons share one timing, so neuron 0 alone flags the scores
	neuron #(.weights(`NN_W0), .bias(`NN_B0)) i_neuron0
	(
		.clk(clk),
		.reset(reset),
		.featureBank(featureBank),
		.frameValid(frameValid),
		.score(neuronScore0),
		.scoreValid(scoreValid)
	);

	neuron #(.weights(`NN_W1), .bias(`NN_B1)) i_neuron1
	(
		.clk(clk),
		.reset(reset),
		.featureBank(featureBank),
		.frameValid(frameValid),
		.score(neuronScore1),
		.scoreValid()
	);

	neuron #(.weights(`NN_W2), .bias(`NN_B2)) i_neuron2
	(
		.clk(clk),
		.reset(reset),
		.featureBank(featureBank),
		.frameValid(frameValid),
		.score(neuronScore2),
		.scoreValid()
	);

	neuron #(.weights(`NN_W3), .bias(`NN_B3)) i_neuron3
	(
		.clk(clk),
		.reset(reset),
		.featureBank(featureBank),
		.frameValid(frameValid),
		.score(neuronScore3),
		.scoreValid()
	);

	resultStage i_resultStage
	(
		.clk(clk),
		.reset(reset),
		.score0(neuronScore0),
		.score1(neuronScore1),
		.score2(neuronScore2),
		.score3(neuronScore3),
		.scoreValid(scoreValid),
		.resultReq(resultReq),
		.resultAck(resultAck),
		.classId(classId),
		.scoreOut0(score0),
		.scoreOut1(score1),
		.scoreOut2(score2),
		.scoreOut3(score3),
		.frameDone(frameDone)
	);

endmodule

// ==== sim/nnChecker.sv ====
`timescale 1ns/10ps
`include "nnLayer_cfg.svh"

module nnChecker
(
	input logic clk,
	input logic reset,
	input logic featureReq,
	input nnPkg::feature_t featureData,
	input logic featureAck,
	input logic resultReq,
	input logic resultAck,
	input nnPkg::classId_t classId,
	input nnPkg::feature_t score0,
	input nnPkg::feature_t score1,
	input nnPkg::feature_t score2,
	input nnPkg::feature_t score3,
	output int passCount,
	output int failCount
);

	localparam int resultLatency = 5; // last featureAck fall to resultReq rise

	string testName;
	int testNumber;
	int tableClass;
	nnPkg::feature_t frame [`NN_FEATURES];
	int slot;
	int expScore [`NN_NEURONS];
	int expClass;
	logic inFlight;
	int cycle;
	int dropCycle;
	logic prevAck;
	logic prevReq;
	logic prevResultAck;
	logic prevReset;
	logic prevFeatureReq;
	nnPkg::feature_t heldData;

	initial
	begin
		passCount = 0;
		failCount = 0;
		testName = "afterReset";
		testNumber = 0;
		tableClass = -1;
		slot = 0;
		inFlight = 1'b0;
		cycle = 0;
		dropCycle = 0;
		prevAck = 1'b0;
		prevReq = 1'b0;
		prevResultAck = 1'b0;
		prevReset = 1'b0;
		prevFeatureReq = 1'b0;
		heldData = '0;
	end

	// the testbench names each frame before sending it
	task automatic startTest(input string name, input int number, input int expectedClass);
		testName = name;
		testNumber = number;
		tableClass = expectedClass;
	endtask

	function automatic int weightOf(input int n, input int i);
		logic [8*`NN_FEATURES-1:0] row;
		case (n)
			0: row = `NN_W0;
			1: row = `NN_W1;
			2: row = `NN_W2;
			default: row = `NN_W3;
		endcase
		return int'($signed(row[8*i +: 8])); // feature i sits in byte i
	endfunction

	function automatic int biasOf(input int n);
		case (n)
			0: return int'(`NN_B0);
			1: return int'(`NN_B1);
			2: return int'(`NN_B2);
			default: return int'(`NN_B3);
		endcase
	endfunction

	// ReLU, then divide by one score step, round half down and clamp
	function automatic int scoreOf(input int acc);
		int step;
		int whole;
		int rest;
		step = 1 << `NN_FRAC_SHIFT;
		if (acc < 0)
			return 0;
		whole = acc / step;
		rest = acc % step;
		if (rest > step / 2)
			whole = whole + 1;
		if (whole > `NN_SAT_MAX)
			whole = `NN_SAT_MAX;
		return whole;
	endfunction

	task automatic computeExpected();
		int acc;
		expClass = 0;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			acc = biasOf(n);
			for (int i = 0; i < `NN_FEATURES; i++)
				acc = acc + int'(frame[i]) * weightOf(n, i);
			expScore[n] = scoreOf(acc);
			if (expScore[n] > expScore[expClass])
				expClass = n; // a tie keeps the lower index
		end
	endtask

	task automatic checkAfterReset();
		if (featureAck !== 1'b0 || resultReq !== 1'b0 || score0 !== '0 || score1 !== '0
			|| score2 !== '0 || score3 !== '0)
		begin
			$display("handshake outputs or scores were not cleared by reset");
			failCount++;
		end
		else
		begin
			$display("[PASS] afterReset");
			passCount++;
		end
	endtask

	task automatic takeFeature();
		if (!prevFeatureReq)
		begin
			$display("featureAck rose without featureReq in test %s #%0d", testName, testNumber);
			failCount++;
		end
		if (inFlight)
		begin
			$display("featureAck rose before the result of test %s #%0d was taken",
				testName, testNumber);
			failCount++;
		end
		frame[slot] = heldData;
		slot++;
		if (slot == `NN_FEATURES)
		begin
			computeExpected();
			slot = 0;
			inFlight = 1'b1;
		end
	endtask

	task automatic checkResult();
		int actual [`NN_NEURONS];
		int errors;
		int latency;
		actual[0] = int'(score0);
		actual[1] = int'(score1);
		actual[2] = int'(score2);
		actual[3] = int'(score3);
		errors = 0;
		latency = cycle - dropCycle;
		if (!inFlight)
		begin
			$display("resultReq rose with no frame sent in test %s #%0d", testName, testNumber);
			errors++;
		end
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			if (actual[n] != expScore[n])
			begin
				$display("[FAIL] %s #%0d score%0d expected %0d actual %0d",
					testName, testNumber, n, expScore[n], actual[n]);
				errors++;
			end
		end
		if (int'(classId) != expClass)
		begin
			$display("[FAIL] %s #%0d classId expected %0d actual %0d",
				testName, testNumber, expClass, int'(classId));
			errors++;
		end
		if (tableClass >= 0 && int'(classId) != tableClass)
		begin
			$display("[FAIL] %s #%0d table classId expected %0d actual %0d",
				testName, testNumber, tableClass, int'(classId));
			errors++;
		end
		if (latency != resultLatency)
		begin
			$display("[FAIL] %s #%0d result latency expected %0d actual %0d",
				testName, testNumber, resultLatency, latency);
			errors++;
		end
		if (errors == 0)
		begin
			$display("[PASS] %s #%0d class %0d scores %0d %0d %0d %0d", testName, testNumber,
				int'(classId), actual[0], actual[1], actual[2], actual[3]);
			passCount++;
		end
		else
			failCount++;
	endtask

	// sampled on the rising edge, before the DUT registers update
	always @(posedge clk)
	begin
		cycle++;
		if (prevReset && !reset)
			checkAfterReset();
		if (!reset)
		begin
			if (featureAck && !prevAck)
				takeFeature();
			if (!featureAck && prevAck && inFlight && slot == 0)
				dropCycle = cycle; // the 15th handshake just closed
			if (resultReq && !prevReq)
				checkResult();
			if (!resultAck && prevResultAck)
				inFlight = 1'b0;
		end
		prevAck = featureAck;
		prevReq = resultReq;
		prevResultAck = resultAck;
		prevReset = reset;
		prevFeatureReq = featureReq;
		if (featureReq)
			heldData = featureData; // the loader captures the feature while req is high
	end

endmodule

// ==== sim/nnLayerTb.sv ====
`timescale 1ns/10ps
`include "nnLayer_cfg.svh"

module nnLayerTb;

	localparam int directedCount = 5;
	localparam int frameCount = directedCount + 30;
	localparam int waitLimit = 200; // cycles before a handshake counts as hung

	logic clk;
	logic reset;
	logic featureReq;
	nnPkg::feature_t featureData;
	logic featureAck;
	logic resultReq;
	logic resultAck;
	nnPkg::classId_t classId;
	nnPkg::feature_t score0;
	nnPkg::feature_t score1;
	nnPkg::feature_t score2;
	nnPkg::feature_t score3;
	int passCount;
	int failCount;
	int timeoutCount;
	integer seed;

	nnPkg::feature_t frames [frameCount][`NN_FEATURES];
	string names [frameCount];
	int classes [frameCount]; // -1 leaves the class to the rule-based check alone

	nnLayer i_nnLayer
	(
		.clk(clk),
		.reset(reset),
		.featureReq(featureReq),
		.featureData(featureData),
		.featureAck(featureAck),
		.resultReq(resultReq),
		.resultAck(resultAck),
		.classId(classId),
		.score0(score0),
		.score1(score1),
		.score2(score2),
		.score3(score3)
	);

	nnChecker i_nnChecker
	(
		.clk(clk),
		.reset(reset),
		.featureReq(featureReq),
		.featureData(featureData),
		.featureAck(featureAck),
		.resultReq(resultReq),
		.resultAck(resultAck),
		.classId(classId),
		.score0(score0),
		.score1(score1),
		.score2(score2),
		.score3(score3),
		.passCount(passCount),
		.failCount(failCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic buildTable();
		for (int i = 0; i < frameCount; i++)
			for (int k = 0; k < `NN_FEATURES; k++)
				frames[i][k] = '0;
		names[0] = "allZero"; // only the biases remain
		classes[0] = 1;
		names[1] = "saturate";
		classes[1] = 0;
		for (int k = 0; k < `NN_FEATURES; k++)
			frames[1][k] = (k inside {1, 3, 5, 9, 11, 12}) ? -8'sd127 : 8'sd127; // follows neuron 0 signs
		names[2] = "halfExact";
		classes[2] = 1;
		frames[2][9] = 8'sd100; // neuron 2 lands on 800, exactly twelve and a half steps
		names[3] = "halfAbove";
		classes[3] = 1;
		frames[3][9] = 8'sd100;
		frames[3][3] = 8'sd3; // neuron 2 lands on 866, two above the half step
		names[4] = "tieTop";
		classes[4] = 1;
		frames[4][2] = 8'sd11;
		frames[4][5] = 8'sd10; // neurons 1 and 3 both score 10
		for (int i = directedCount; i < frameCount; i++)
		begin
			names[i] = "random";
			classes[i] = -1;
			for (int k = 0; k < `NN_FEATURES; k++)
				frames[i][k] = nnPkg::feature_t'($random(seed));
		end
	endtask

	task automatic sendFeature(input int index, input nnPkg::feature_t value, output bit ok);
		int n;
		@(negedge clk);
		featureData = value;
		featureReq = 1'b1;
		n = 0;
		while (!featureAck && n < waitLimit)
		begin
			@(negedge clk);
			n++;
		end
		ok = featureAck;
		if (!ok)
			$display("no featureAck for test %s #%0d", names[index], index);
		else
		begin
			featureReq = 1'b0;
			n = 0;
			while (featureAck && n < waitLimit)
			begin
				@(negedge clk);
				n++;
			end
			ok = !featureAck;
			if (!ok)
				$display("featureAck never dropped in test %s #%0d", names[index], index);
		end
		if (!ok)
			timeoutCount++;
	endtask

	task automatic takeResult(input int index, output bit ok);
		int n;
		int delay;
		n = 0;
		while (!resultReq && n < waitLimit)
		begin
			@(negedge clk);
			n++;
		end
		ok = resultReq;
		if (!ok)
			$display("no resultReq for test %s #%0d", names[index], index);
		else
		begin
			// in the random run the next frame already knocks while the loader is busy
			if (index >= directedCount && index + 1 < frameCount)
			begin
				featureData = frames[index + 1][0];
				featureReq = 1'b1;
			end
			delay = (index >= directedCount) ? ($random(seed) & 32'h7) : 0;
			for (n = 0; n < delay; n++)
				@(negedge clk);
			resultAck = 1'b1;
			n = 0;
			while (resultReq && n < waitLimit)
			begin
				@(negedge clk);
				n++;
			end
			ok = !resultReq;
			resultAck = 1'b0;
			if (!ok)
				$display("resultReq never dropped in test %s #%0d", names[index], index);
		end
		if (!ok)
			timeoutCount++;
	endtask

	initial
	begin
		bit ok;
		seed = 32'h5bff;
		timeoutCount = 0;
		reset = 1'b1;
		featureReq = 1'b0;
		featureData = '0;
		resultAck = 1'b0;
		buildTable();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		ok = 1'b1;
		for (int i = 0; i < frameCount && ok; i++)
		begin
			i_nnChecker.startTest(names[i], i, classes[i]);
			for (int k = 0; k < `NN_FEATURES && ok; k++)
				sendFeature(i, frames[i][k], ok);
			if (ok)
				takeResult(i, ok);
		end
		repeat (4) @(negedge clk);
		$display("%0d tests passed, %0d failed, %0d timeouts", passCount, failCount, timeoutCount);
		if (failCount == 0 && timeoutCount == 0 && passCount == frameCount + 1)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+design
design/nnPkg.sv
design/featureLoader.sv
design/neuron.sv
design/resultStage.sv
design/nnLayer.sv
sim/nnChecker.sv
sim/nnLayerTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module nnLayerTb \
	-o nnLayerSim > build.log 2>&1 \
	&& ./obj_dir/nnLayerSim > sim.log 2>&1 \
	|| { cat build.log; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
